// ==== dds_mod_pkg.sv ====
package dds_mod_pkg;

   ////////////////////////////////////////////////////////////
   // widths and constants
   ////////////////////////////////////////////////////////////
   localparam int SAMPLE_W   = 12;
   localparam int PHASE_W    = 32;
   localparam int LUT_ADDR_W = 6;     // 64-entry quarter wave
   localparam int LFSR_W     = 5;

   localparam logic [LFSR_W-1:0] LFSR_TAPS = 5'b10100;   // x^5 + x^3 + 1, right shift
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;

   localparam int SYMBOL_PERIOD_DEFAULT = 25_000_000;   // one step per second at 25 MHz

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [PHASE_W-1:0]         phase_t;

   localparam sample_t SAMPLE_MAX = 2047;

   ////////////////////////////////////////////////////////////
   // keyboard event codes, bit 7 marks a release
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] SC_MAKE_1      = 8'h16;
   localparam logic [7:0] SC_MAKE_2      = 8'h1e;
   localparam logic [7:0] SC_MAKE_3      = 8'h26;
   localparam logic [7:0] SC_MAKE_4      = 8'h25;
   localparam logic [7:0] SC_MAKE_5      = 8'h2e;
   localparam logic [7:0] SC_MAKE_6      = 8'h36;
   localparam logic [7:0] SC_MAKE_7      = 8'h3d;
   localparam logic [7:0] SC_MAKE_8      = 8'h3e;
   localparam logic [7:0] SC_MAKE_F1     = 8'h05;
   localparam logic [7:0] SC_MAKE_F2     = 8'h06;
   localparam logic [7:0] SC_MAKE_N      = 8'h31;
   localparam logic [7:0] SC_MAKE_M      = 8'h3a;
   localparam logic [7:0] SC_MAKE_SPACE  = 8'h29;
   localparam logic [7:0] SC_MAKE_LEFT   = 8'h6b;   // extended codes, prefix already stripped
   localparam logic [7:0] SC_MAKE_RIGHT  = 8'h74;
   localparam logic [7:0] SC_MAKE_UP     = 8'h75;
   localparam logic [7:0] SC_MAKE_DOWN   = 8'h72;

   localparam logic [7:0] SC_BREAK_1     = SC_MAKE_1 | 8'h80;
   localparam logic [7:0] SC_BREAK_2     = SC_MAKE_2 | 8'h80;
   localparam logic [7:0] SC_BREAK_3     = SC_MAKE_3 | 8'h80;
   localparam logic [7:0] SC_BREAK_4     = SC_MAKE_4 | 8'h80;
   localparam logic [7:0] SC_BREAK_5     = SC_MAKE_5 | 8'h80;
   localparam logic [7:0] SC_BREAK_6     = SC_MAKE_6 | 8'h80;
   localparam logic [7:0] SC_BREAK_7     = SC_MAKE_7 | 8'h80;
   localparam logic [7:0] SC_BREAK_8     = SC_MAKE_8 | 8'h80;
   localparam logic [7:0] SC_BREAK_F1    = SC_MAKE_F1 | 8'h80;
   localparam logic [7:0] SC_BREAK_F2    = SC_MAKE_F2 | 8'h80;
   localparam logic [7:0] SC_BREAK_N     = SC_MAKE_N | 8'h80;
   localparam logic [7:0] SC_BREAK_M     = SC_MAKE_M | 8'h80;
   localparam logic [7:0] SC_BREAK_SPACE = SC_MAKE_SPACE | 8'h80;
   localparam logic [7:0] SC_BREAK_LEFT  = SC_MAKE_LEFT | 8'h80;
   localparam logic [7:0] SC_BREAK_RIGHT = SC_MAKE_RIGHT | 8'h80;
   localparam logic [7:0] SC_BREAK_UP    = SC_MAKE_UP | 8'h80;
   localparam logic [7:0] SC_BREAK_DOWN  = SC_MAKE_DOWN | 8'h80;

   ////////////////////////////////////////////////////////////
   // shared types
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic key_1, key_2, key_3, key_4, key_5, key_6, key_7, key_8;
      logic f1, f2, n, m, space;
      logic left, right, up, down;
   } held_keys_t;

   typedef enum logic [1:0] {WAVE_SIN, WAVE_COS, WAVE_SQU, WAVE_SAW} wave_sel_e;
   typedef enum logic [1:0] {MOD_NONE, MOD_ASK, MOD_BPSK} mod_sel_e;

   typedef struct packed {
      wave_sel_e wave;
      mod_sel_e  mode;
   } sel_t;

   // all four samples of one phase, plus the symbol that goes with them
   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t squ;
      sample_t saw;
      logic    symbol;
   } wave_set_t;

endpackage

// ==== scan_code_decoder.sv ====
`timescale 1ns/1ps
module scan_code_decoder (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   event_ready,
   input  logic [7:0]             event_type,
   output dds_mod_pkg::held_keys_t held_keys,
   output dds_mod_pkg::sel_t       sel
);
   import dds_mod_pkg::*;

   held_keys_t keys_next;
   sel_t       sel_next;

   // one flag per key, only touched on a strobe
   always_comb
   begin
      keys_next = held_keys;
      if (event_ready)
      begin
         case (event_type)
            SC_MAKE_1:      keys_next.key_1 = 1'b1;
            SC_BREAK_1:     keys_next.key_1 = 1'b0;
            SC_MAKE_2:      keys_next.key_2 = 1'b1;
            SC_BREAK_2:     keys_next.key_2 = 1'b0;
            SC_MAKE_3:      keys_next.key_3 = 1'b1;
            SC_BREAK_3:     keys_next.key_3 = 1'b0;
            SC_MAKE_4:      keys_next.key_4 = 1'b1;
            SC_BREAK_4:     keys_next.key_4 = 1'b0;
            SC_MAKE_5:      keys_next.key_5 = 1'b1;
            SC_BREAK_5:     keys_next.key_5 = 1'b0;
            SC_MAKE_6:      keys_next.key_6 = 1'b1;
            SC_BREAK_6:     keys_next.key_6 = 1'b0;
            SC_MAKE_7:      keys_next.key_7 = 1'b1;
            SC_BREAK_7:     keys_next.key_7 = 1'b0;
            SC_MAKE_8:      keys_next.key_8 = 1'b1;
            SC_BREAK_8:     keys_next.key_8 = 1'b0;
            SC_MAKE_F1:     keys_next.f1 = 1'b1;
            SC_BREAK_F1:    keys_next.f1 = 1'b0;
            SC_MAKE_F2:     keys_next.f2 = 1'b1;
            SC_BREAK_F2:    keys_next.f2 = 1'b0;
            SC_MAKE_N:      keys_next.n = 1'b1;
            SC_BREAK_N:     keys_next.n = 1'b0;
            SC_MAKE_M:      keys_next.m = 1'b1;
            SC_BREAK_M:     keys_next.m = 1'b0;
            SC_MAKE_SPACE:  keys_next.space = 1'b1;
            SC_BREAK_SPACE: keys_next.space = 1'b0;
            SC_MAKE_LEFT:   keys_next.left = 1'b1;
            SC_BREAK_LEFT:  keys_next.left = 1'b0;
            SC_MAKE_RIGHT:  keys_next.right = 1'b1;
            SC_BREAK_RIGHT: keys_next.right = 1'b0;
            SC_MAKE_UP:     keys_next.up = 1'b1;
            SC_BREAK_UP:    keys_next.up = 1'b0;
            SC_MAKE_DOWN:   keys_next.down = 1'b1;
            SC_BREAK_DOWN:  keys_next.down = 1'b0;
            default:        keys_next = held_keys;   // unused code
         endcase
      end
   end

   // lowest held number key wins, F1 over F2
   always_comb
   begin
      if (keys_next.key_1)      sel_next.wave = WAVE_SIN;
      else if (keys_next.key_2) sel_next.wave = WAVE_COS;
      else if (keys_next.key_3) sel_next.wave = WAVE_SQU;
      else if (keys_next.key_4) sel_next.wave = WAVE_SAW;
      else                      sel_next.wave = WAVE_SIN;
      if (keys_next.f1)         sel_next.mode = MOD_ASK;
      else if (keys_next.f2)    sel_next.mode = MOD_BPSK;
      else                      sel_next.mode = MOD_NONE;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
         sel       <= '{wave: WAVE_SIN, mode: MOD_NONE};
      end
      else
      begin
         held_keys <= keys_next;
         sel       <= sel_next;   // same clock as the flags
      end
   end

endmodule

// ==== lfsr_symbol_gen.sv ====
`timescale 1ns/1ps
module lfsr_symbol_gen #(
   parameter int symbol_period = dds_mod_pkg::SYMBOL_PERIOD_DEFAULT
) (
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic symbol
);
   import dds_mod_pkg::*;

   logic [31:0]       tick_cnt;
   logic              step;
   logic [LFSR_W-1:0] lfsr;

   ////////////////////////////////////////////////////////////
   // step enable, replaces the old 1 Hz clock
   ////////////////////////////////////////////////////////////
   assign step = (tick_cnt == 32'(symbol_period - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
      end
      else if (step)
      begin
         tick_cnt <= '0;   // wrap
      end
      else
      begin
         tick_cnt <= tick_cnt + 32'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // galois lfsr, shift right and fold taps back in
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= LFSR_SEED;
      end
      else if (step)
      begin
         lfsr <= (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : '0);
      end
   end

   assign symbol = lfsr[0];

endmodule

// ==== dds_waveform_gen.sv ====
`timescale 1ns/1ps
module dds_waveform_gen (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_mod_pkg::phase_t    phase_inc,
   input  logic                  symbol,
   output dds_mod_pkg::wave_set_t wave_set
);
   import dds_mod_pkg::*;

   phase_t  phase_q;
   logic    symbol_q;      // stays beside the phase it belongs to
   sample_t quarter_rom [0:(1 << LUT_ADDR_W) - 1];

   logic [LUT_ADDR_W+1:0] sin_idx;
   logic [LUT_ADDR_W+1:0] cos_idx;
   wave_set_t             wave_next;

   initial
   begin
      $readmemh("quarter_sine.mem", quarter_rom);
   end

   // full-circle lookup from one quadrant
   function automatic sample_t sine_of(input logic [LUT_ADDR_W+1:0] idx);
      logic [1:0]            quad;
      logic [LUT_ADDR_W-1:0] addr;
      sample_t               mag;
      quad = idx[LUT_ADDR_W+1:LUT_ADDR_W];
      addr = quad[0] ? ~idx[LUT_ADDR_W-1:0] : idx[LUT_ADDR_W-1:0];   // 63 - index
      mag  = quarter_rom[addr];
      return quad[1] ? -mag : mag;   // lower half of the circle
   endfunction

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_q  <= '0;
         symbol_q <= 1'b0;
      end
      else
      begin
         phase_q  <= phase_q + phase_inc;   // wraps mod 2^32
         symbol_q <= symbol;
      end
   end

   ////////////////////////////////////////////////////////////
   // waveforms from the current phase
   ////////////////////////////////////////////////////////////
   assign sin_idx = phase_q[PHASE_W-1 -: LUT_ADDR_W+2];
   assign cos_idx = sin_idx + {2'b01, {LUT_ADDR_W{1'b0}}};   // quarter turn ahead

   always_comb
   begin
      wave_next.sin    = sine_of(sin_idx);
      wave_next.cos    = sine_of(cos_idx);
      wave_next.squ    = phase_q[PHASE_W-1] ? -SAMPLE_MAX : SAMPLE_MAX;
      // offset binary ramp turned into two's complement
      wave_next.saw    = {~phase_q[PHASE_W-1], phase_q[PHASE_W-2 -: SAMPLE_W-1]};
      wave_next.symbol = symbol_q;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_set <= '0;
      end
      else
      begin
         wave_set <= wave_next;
      end
   end

endmodule

// ==== modulation_unit.sv ====
`timescale 1ns/1ps
module modulation_unit (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_mod_pkg::wave_set_t wave_set,
   input  dds_mod_pkg::sel_t      sel,
   output dds_mod_pkg::sample_t   mod_sample
);
   import dds_mod_pkg::*;

   sample_t picked;
   sample_t shaped;

   // waveform pick
   always_comb
   begin
      case (sel.wave)
         WAVE_SIN: picked = wave_set.sin;
         WAVE_COS: picked = wave_set.cos;
         WAVE_SQU: picked = wave_set.squ;
         WAVE_SAW: picked = wave_set.saw;
         default:  picked = wave_set.sin;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // ask gates on symbol 0, bpsk flips the sign
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      case (sel.mode)
         MOD_ASK:
         begin
            shaped = wave_set.symbol ? picked : '0;
         end
         MOD_BPSK:
         begin
            shaped = wave_set.symbol ? picked : -picked;
         end
         default:
         begin
            shaped = picked;   // carrier only
         end
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         mod_sample <= '0;
      end
      else
      begin
         mod_sample <= shaped;
      end
   end

endmodule

// ==== dds_mod_top.sv ====
`timescale 1ns/1ps
module dds_mod_top #(
   parameter int symbol_period = dds_mod_pkg::SYMBOL_PERIOD_DEFAULT
) (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   event_ready,
   input  logic [7:0]             event_type,
   input  dds_mod_pkg::phase_t     phase_inc,
   output dds_mod_pkg::held_keys_t held_keys,
   output dds_mod_pkg::sample_t    mod_sample
);
   import dds_mod_pkg::*;

   sel_t      sel;
   logic      symbol;
   wave_set_t wave_set;

   ////////////////////////////////////////////////////////////
   // decode, generate, modulate
   ////////////////////////////////////////////////////////////
   scan_code_decoder decoder_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_ready    (event_ready),
      .event_type     (event_type),
      .held_keys      (held_keys),
      .sel            (sel)
   );

   lfsr_symbol_gen #(.symbol_period(symbol_period)) lfsr_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .symbol         (symbol)
   );

   dds_waveform_gen dds_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .symbol         (symbol),
      .wave_set       (wave_set)
   );

   modulation_unit mod_inst (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_set       (wave_set),
      .sel            (sel),
      .mod_sample     (mod_sample)   // two clocks behind the phase
   );

endmodule

// ==== tb_dds_mod_checker.sv ====
`timescale 1ns/1ps
module tb_dds_mod_checker #(
   parameter int symbol_period = 16
) (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   event_ready,
   input  logic [7:0]             event_type,
   input  dds_mod_pkg::phase_t     phase_inc,
   input  dds_mod_pkg::held_keys_t held_keys,
   input  dds_mod_pkg::sample_t    mod_sample,
   output int                     errors,
   output int                     checks
);
   import dds_mod_pkg::*;

   sample_t           qtable [0:63];
   logic [7:0]        make_codes [0:16];   // same order as the held_keys fields
   logic [16:0]       keys_m;
   phase_t            phase_m;
   logic              symq_m;
   logic [LFSR_W-1:0] lfsr_m;
   int                tick_m;
   wave_set_t         wave_m;
   sample_t           mod_m;
   logic              model_ok;

   initial
   begin
      $readmemh("quarter_sine.mem", qtable);
      make_codes = '{SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
                     SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
                     SC_MAKE_SPACE, SC_MAKE_LEFT, SC_MAKE_RIGHT, SC_MAKE_UP, SC_MAKE_DOWN};
      errors   = 0;
      checks   = 0;
      model_ok = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////////////////////////
   function automatic sample_t sine_at(input phase_t ph);
      logic [1:0] quad;
      int         idx;
      sample_t    v;
      quad = ph[31:30];
      idx  = ph[29:24];
      if (quad == 2'd1 || quad == 2'd3)
         idx = 63 - idx;   // mirrored quadrants
      v = qtable[idx];
      if (quad[1])
         v = -v;
      return v;
   endfunction

   function automatic logic [16:0] decode(input logic [16:0] k, input logic rdy,
                                          input logic [7:0] code);
      logic [16:0] f;
      int          i;
      f = k;
      for (i = 0; i < 17; i++)
      begin
         if (rdy && code == make_codes[i])
            f[16 - i] = 1'b1;
         if (rdy && code == (make_codes[i] | 8'h80))
            f[16 - i] = 1'b0;   // release
      end
      return f;
   endfunction

   function automatic sample_t expect_out(input wave_set_t w, input held_keys_t k);
      sample_t s;
      if (k.key_1)      s = w.sin;
      else if (k.key_2) s = w.cos;
      else if (k.key_3) s = w.squ;
      else if (k.key_4) s = w.saw;
      else              s = w.sin;
      if (k.f1)
         return w.symbol ? s : sample_t'(0);
      if (k.f2)
         return w.symbol ? s : sample_t'(-s);
      return s;
   endfunction

   ////////////////////////////////////////////////////////////
   // compare on the falling edge, then advance the model
   ////////////////////////////////////////////////////////////
   always @(negedge CLK_25MHZ)
   begin
      if (model_ok)
      begin
         checks = checks + 1;
         if (held_keys !== keys_m)
         begin
            errors = errors + 1;
            $display("ERROR %0t: held_keys %h, expected %h", $time, held_keys, keys_m);
         end
         if (mod_sample !== mod_m)
         begin
            errors = errors + 1;
            $display("ERROR %0t: mod_sample %0d, expected %0d", $time, mod_sample, mod_m);
         end
      end
      if (reset_from_key)
      begin
         keys_m   = '0;
         phase_m  = '0;
         symq_m   = 1'b0;
         lfsr_m   = LFSR_SEED;
         tick_m   = 0;
         wave_m   = '0;
         mod_m    = '0;
         model_ok = 1'b1;
      end
      else
      begin
         mod_m  = expect_out(wave_m, keys_m);   // old samples, current keys
         wave_m = '{sin: sine_at(phase_m),
                    cos: sine_at(phase_m + 32'h4000_0000),
                    squ: phase_m[31] ? -SAMPLE_MAX : SAMPLE_MAX,
                    saw: $signed(phase_m[31:20] ^ 12'h800),
                    symbol: symq_m};
         symq_m  = lfsr_m[0];
         phase_m = phase_m + phase_inc;
         if (tick_m == symbol_period - 1)
         begin
            tick_m = 0;
            lfsr_m = lfsr_m[0] ? ((lfsr_m >> 1) ^ LFSR_TAPS) : (lfsr_m >> 1);
         end
         else
         begin
            tick_m = tick_m + 1;
         end
         keys_m = decode(keys_m, event_ready, event_type);
      end
   end

endmodule

// ==== tb_dds_mod_assert.sv ====
`timescale 1ns/1ps
module tb_dds_mod_assert (
   input logic                   CLK_25MHZ,
   input logic                   reset_from_key,
   input dds_mod_pkg::wave_set_t wave_set,
   input dds_mod_pkg::sel_t      sel,
   input dds_mod_pkg::sample_t   mod_sample
);
   import dds_mod_pkg::*;

   int fails = 0;

   // output cleared one edge into reset
   reset_clears: assert property (@(posedge CLK_25MHZ) reset_from_key |=> mod_sample == '0)
      else
      begin
         $error("mod_sample not cleared by reset");
         fails++;
      end

   ask_gates: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (sel.mode == MOD_ASK && !wave_set.symbol) |=> mod_sample == '0)
      else
      begin
         $error("ASK with symbol 0 did not give zero");
         fails++;
      end

   sel_known: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$isunknown(sel))
      else
      begin
         $error("sel holds unknown bits");
         fails++;
      end

endmodule

// ==== tb_dds_mod.sv ====
`timescale 1ns/1ps
module tb_dds_mod;
   import dds_mod_pkg::*;

   localparam int sym_period = 16;

   logic        CLK_25MHZ;
   logic        reset_from_key;
   logic        event_ready;
   logic [7:0]  event_type;
   phase_t      phase_inc;
   held_keys_t  held_keys;
   sample_t     mod_sample;
   int          errors;
   int          checks;
   int          mark_errors;
   int          mark_checks;
   int          test_count;
   int          stalls;        // waits that ran out
   logic [31:0] rng_state;
   logic [16:0] intent;        // keys the stimulus means to hold
   logic [7:0]  key_codes [0:16];

   dds_mod_top #(.symbol_period(sym_period)) uut (.*);

   tb_dds_mod_checker #(.symbol_period(sym_period)) checker_inst (.*);

   bind modulation_unit tb_dds_mod_assert mod_props (.*);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      #(40 * 8000);
      $display("timeout: simulation ran past its cycle limit");
      $display("*** FAILED ***");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v = {v[30:0], rng_state[0]};
         rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'h8020_0003) : (rng_state >> 1);
      end
      return v;
   endfunction

   task automatic tick();
      @(posedge CLK_25MHZ);
      #2;
   endtask

   task automatic send_event(input logic [7:0] code);
      event_ready = 1'b1;
      event_type  = code;
      tick();
      event_ready = 1'b0;
      event_type  = 8'(rand_bits(8));   // junk while idle
   endtask

   task automatic wait_keys();
      int n;
      n = 0;
      while (held_keys !== intent && n < 8)
      begin
         tick();
         n++;
      end
      if (held_keys !== intent)
      begin
         stalls++;
         $display("timeout: held keys never reached %h", intent);
      end
   endtask

   task automatic press(input int idx, input logic down);
      send_event(down ? key_codes[idx] : (key_codes[idx] | 8'h80));
      intent[16 - idx] = down;
      wait_keys();
   endtask

   task automatic release_all();
      int i;
      for (i = 0; i < 17; i++)
         send_event(key_codes[i] | 8'h80);
      intent = '0;
      wait_keys();
   endtask

   task automatic run_cycles(input int n);
      int i;
      for (i = 0; i < n; i++)
      begin
         if (rand_bits(3) == 0)
            phase_inc = rand_bits(28);   // new tone now and then
         event_type = 8'(rand_bits(8));
         tick();
      end
   endtask

   task automatic report_test(input string name);
      test_count++;
      $display("test %0d %s: %0d checks, %0d errors", test_count, name,
               checks - mark_checks, errors - mark_errors);
      mark_errors = errors;
      mark_checks = checks;
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////
   initial
   begin
      int i;
      int w;
      int fails_total;
      reset_from_key = 1'b1;
      event_ready    = 1'b0;
      event_type     = 8'h00;
      phase_inc      = '0;
      rng_state      = 32'h9bfa0101;
      intent         = '0;
      mark_errors    = 0;
      mark_checks    = 0;
      test_count     = 0;
      stalls         = 0;
      key_codes = '{SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
                    SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
                    SC_MAKE_SPACE, SC_MAKE_LEFT, SC_MAKE_RIGHT, SC_MAKE_UP, SC_MAKE_DOWN};
      repeat (2) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      for (i = 0; i < 8; i++)
         tick();   // phase stays at zero
      report_test("reset and first sample");

      for (i = 0; i < 300; i++)
      begin
         event_ready = 1'(rand_bits(1));
         if (rand_bits(2) == 0)
            event_type = 8'(rand_bits(8));
         else
            event_type = key_codes[rand_bits(5) % 17] | (rand_bits(1) ? 8'h80 : 8'h00);
         if (rand_bits(4) == 0)
            phase_inc = rand_bits(28);
         tick();
      end
      event_ready = 1'b0;
      report_test("random key events");

      for (w = 0; w < 4; w++)
      begin
         release_all();
         press(w, 1'b1);
         run_cycles(60);
      end
      report_test("waveforms without modulation");

      release_all();
      press(8, 1'b1);   // F1
      for (w = 3; w >= 0; w--)
      begin
         press(w, 1'b1);
         run_cycles(80);
      end
      report_test("ASK");

      release_all();
      press(9, 1'b1);   // F2
      for (w = 3; w >= 0; w--)
      begin
         press(w, 1'b1);
         run_cycles(50);
      end
      press(8, 1'b1);
      run_cycles(80);
      report_test("BPSK and F1 priority");

      release_all();
      for (w = 3; w >= 0; w--)
      begin
         press(w, 1'b1);
         run_cycles(12);
      end
      for (w = 0; w < 4; w++)
      begin
         press(w, 1'b0);
         run_cycles(12);   // ends on sine
      end
      report_test("waveform key priority");

      fails_total = uut.mod_inst.mod_props.fails;
      $display("summary: %0d tests, %0d checks, %0d errors, %0d timeouts, %0d assertion fails",
               test_count, checks, errors, stalls, fails_total);
      if (errors == 0 && stalls == 0 && fails_total == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== quarter_sine.mem ====
// quarter sine table, one signed 12-bit sample per line in hex, index 0 to 63
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
326
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF

// ==== flist.f ====
dds_mod_pkg.sv
scan_code_decoder.sv
lfsr_symbol_gen.sv
dds_waveform_gen.sv
modulation_unit.sv
dds_mod_top.sv
tb_dds_mod_checker.sv
tb_dds_mod_assert.sv
tb_dds_mod.sv

// ==== Bender.yml ====
package:
  name: dds_mod

sources:
  - dds_mod_pkg.sv
  - scan_code_decoder.sv
  - lfsr_symbol_gen.sv
  - dds_waveform_gen.sv
  - modulation_unit.sv
  - dds_mod_top.sv
  - target: test
    files:
      - tb_dds_mod_checker.sv
      - tb_dds_mod_assert.sv
      - tb_dds_mod.sv
